//--- source/fma_align_add.sv
/*
 * Stage 3 of the FMA pipeline.
 * Resolves special results first, else aligns product and c in a
 * 96-bit field with the leading one at bit 94, leaving bit 95 for the
 * carry. Bits shifted out of the smaller operand are dropped.
 */
`timescale 1ns/1ns
`default_nettype none
`include "fma_defines.svh"

module fma_align_add import fp32_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            in_valid,
    input  wire product_stage_t  in,
    output logic                 out_valid,
    output sum_stage_t           out
);

    logic signed [9:0] c_exp_eff;
    logic              prod_bigger;   // Product exponent >= c exponent
    logic [9:0]        shift;
    logic [95:0]       prod_ext;
    logic [95:0]       c_ext;
    logic [95:0]       prod_al;
    logic [95:0]       c_al;
    sum_stage_t        nxt;

    // ------------------------------------------------------------------
    // Alignment
    // ------------------------------------------------------------------
    assign c_exp_eff   = (in.c_exp == 8'h00) ? 10'sd1 : $signed({2'b00, in.c_exp});
    assign prod_bigger = in.prod_exp >= c_exp_eff;
    assign shift       = prod_bigger ? in.prod_exp - c_exp_eff : c_exp_eff - in.prod_exp;

    assign prod_ext = {1'b0, in.prod_mant, 47'h0};
    assign c_ext    = {1'b0, in.c_mant, 71'h0};
    assign prod_al  = prod_bigger ? prod_ext : prod_ext >> shift;
    assign c_al     = prod_bigger ? c_ext >> shift : c_ext;

    // ------------------------------------------------------------------
    // Special selection and add or subtract
    // ------------------------------------------------------------------
    always_comb begin
        nxt     = '0;
        nxt.exp = prod_bigger ? in.prod_exp : c_exp_eff;
        if (in.prod_class.is_nan || in.class_c.is_nan) begin
            nxt.special        = 1'b1;
            nxt.special_result = `FMA_QNAN;
        end else if (in.prod_class.is_inf && in.class_c.is_inf
                     && (in.prod_sign != in.c_sign)) begin
            nxt.special        = 1'b1;            // Inf minus inf
            nxt.special_result = `FMA_QNAN;
        end else if (in.prod_class.is_inf) begin
            nxt.special        = 1'b1;
            nxt.special_result = {in.prod_sign, 8'hFF, 23'h0};
        end else if (in.class_c.is_inf) begin
            nxt.special        = 1'b1;
            nxt.special_result = {in.c_sign, 8'hFF, 23'h0};
        end else if (in.prod_class.is_zero) begin
            nxt.special        = 1'b1;            // c goes out bit for bit
            nxt.special_result = {in.c_sign, in.c_exp, in.c_mant[22:0]};
        end else if (in.class_c.is_zero) begin
            nxt.sign = in.prod_sign;
            nxt.exp  = in.prod_exp;
            nxt.mag  = prod_ext;
        end else if (in.prod_sign == in.c_sign) begin
            nxt.sign = in.prod_sign;
            nxt.mag  = prod_al + c_al;
        end else if (prod_al >= c_al) begin
            nxt.sign = in.prod_sign;
            nxt.mag  = prod_al - c_al;
        end else begin
            nxt.sign = in.c_sign;
            nxt.mag  = c_al - prod_al;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out <= nxt;
        end
    end

endmodule

`default_nettype wire

//--- source/fma_defines.svh
/*
 * Build-time constants of the FMA unit.
 * Register addresses are word addresses on the 3-bit Wishbone adr field.
 * The queue depth bounds the number of operations that can be in flight.
 */
`ifndef FMA_DEFINES_SVH
`define FMA_DEFINES_SVH

`define FMA_LATENCY      4
`define FMA_QUEUE_DEPTH  4

// Register map
`define FMA_ADDR_A       3'd0
`define FMA_ADDR_B       3'd1
`define FMA_ADDR_C       3'd2
`define FMA_ADDR_RESULT  3'd3
`define FMA_ADDR_STATUS  3'd4

// Every NaN result uses this one quiet pattern
`define FMA_QNAN         32'h7FC00001

`endif

//--- source/fma_normalize.sv
/*
 * Stage 4 of the FMA pipeline.
 * Normalizes the 96-bit magnitude, then packs with truncation.
 * A zero magnitude gives +0, exponents from 255 up give infinity
 * and exponents of 0 or below are shifted into a subnormal.
 */
`timescale 1ns/1ns
`default_nettype none

module fma_normalize import fp32_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        in_valid,
    input  wire sum_stage_t  in,
    output logic             out_valid,
    output fp32_u            out
);

    logic [6:0]        lz;
    logic [95:0]       norm;
    logic signed [9:0] norm_exp;
    logic [9:0]        sub_shift;
    logic [22:0]       sub_mant;
    fp32_u             res_word;

    // Leading zeros above the target bit 94
    function automatic logic [6:0] lead_zeros(input logic [94:0] v);
        logic [6:0] n;
        n = 7'd95;
        for (int i = 0; i < 95; i++) begin
            if (v[i]) begin
                n = 7'(94 - i);
            end
        end
        return n;
    endfunction

    assign lz = lead_zeros(in.mag[94:0]);

    always_comb begin
        if (in.mag[95]) begin            // Carry out of the add
            norm     = in.mag >> 1;
            norm_exp = in.exp + 10'sd1;
        end else begin
            norm     = in.mag << lz;
            norm_exp = in.exp - $signed({3'b000, lz});
        end
    end

    assign sub_shift = 10'sd1 - norm_exp;
    assign sub_mant  = 23'(norm[94:71] >> sub_shift);

    // ------------------------------------------------------------------
    // Pack
    // ------------------------------------------------------------------
    always_comb begin
        res_word.raw = 32'h0;
        if (in.special) begin
            res_word.raw = in.special_result;
        end else if (in.mag == '0) begin
            res_word.raw = 32'h0;        // Exact cancellation
        end else if (norm_exp >= 10'sd255) begin
            res_word.f = {in.sign, 8'hFF, 23'h0};
        end else if (norm_exp <= 10'sd0) begin
            res_word.f = {in.sign, 8'h00, sub_mant};
        end else begin
            res_word.f = {in.sign, norm_exp[7:0], norm[93:71]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out <= res_word;
        end
    end

endmodule

`default_nettype wire

//--- source/fma_product.sv
/*
 * Stage 2 of the FMA pipeline.
 * Full 24x24 mantissa product, normalized once so that the leading one
 * of a normal product lands on bit 47. Subnormal inputs may leave
 * leading zeros, which stage 4 removes.
 */
`timescale 1ns/1ns
`default_nettype none

module fma_product import fp32_pkg::*; (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           in_valid,
    input  wire unpack_stage_t  in,
    output logic                out_valid,
    output product_stage_t      out
);

    logic [47:0] raw_prod;
    fp_class_t   pcls;

    assign raw_prod = in.mant_a * in.mant_b;

    // Class of a times b
    assign pcls.is_nan  = in.class_a.is_nan || in.class_b.is_nan
                       || (in.class_a.is_inf && in.class_b.is_zero)
                       || (in.class_a.is_zero && in.class_b.is_inf);
    assign pcls.is_inf  = in.class_a.is_inf || in.class_b.is_inf;
    assign pcls.is_zero = in.class_a.is_zero || in.class_b.is_zero;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            if (raw_prod[47]) begin             // Product in [2,4)
                out.prod_mant <= raw_prod;
                out.prod_exp  <= in.prod_exp + 10'sd1;
            end else begin
                out.prod_mant <= raw_prod << 1;
                out.prod_exp  <= in.prod_exp;
            end
            out.prod_sign  <= in.prod_sign;
            out.prod_class <= pcls;
            out.c_sign     <= in.c_sign;
            out.c_exp      <= in.c_exp;
            out.c_mant     <= in.c_mant;
            out.class_c    <= in.class_c;
        end
    end

endmodule

`default_nettype wire

//--- source/fma_top.sv
/*
 * FMA unit top level computing a * b + c.
 * Register block on the Wishbone side, then four pipeline stages.
 * Results come back through the register block's result queue.
 */
`timescale 1ns/1ns
`default_nettype none

module fma_top import fp32_pkg::*, wb_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire wb_req_t  bus_req,
    output wb_rsp_t       bus_rsp
);

    logic           issue_valid;
    fp32_u          issue_a;
    fp32_u          issue_b;
    fp32_u          issue_c;
    logic           s1_valid;
    unpack_stage_t  s1;
    logic           s2_valid;
    product_stage_t s2;
    logic           s3_valid;
    sum_stage_t     s3;
    logic           res_valid;
    fp32_u          res;

    fma_wb_regs u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus_req      (bus_req),
        .bus_rsp      (bus_rsp),
        .issue_valid  (issue_valid),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .issue_c      (issue_c),
        .result_valid (res_valid),
        .result       (res)
    );

    // ------------------------------------------------------------------
    // Pipeline
    // ------------------------------------------------------------------
    fma_unpack u_unpack (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (issue_valid),
        .a         (issue_a),
        .b         (issue_b),
        .c         (issue_c),
        .out_valid (s1_valid),
        .out       (s1)
    );

    fma_product u_product (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (s1_valid),
        .in        (s1),
        .out_valid (s2_valid),
        .out       (s2)
    );

    fma_align_add u_align_add (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (s2_valid),
        .in        (s2),
        .out_valid (s3_valid),
        .out       (s3)
    );

    fma_normalize u_normalize (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (s3_valid),
        .in        (s3),
        .out_valid (res_valid),
        .out       (res)
    );

endmodule

`default_nettype wire

//--- source/fma_unpack.sv
/*
 * Stage 1 of the FMA pipeline.
 * Splits a, b and c into fields and flags NaN, infinity and zero.
 * Subnormals get a zero hidden bit and count as exponent 1 in the
 * product exponent sum. One cycle of latency, never stalls.
 */
`timescale 1ns/1ns
`default_nettype none

module fma_unpack import fp32_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    in_valid,
    input  wire fp32_u   a,
    input  wire fp32_u   b,
    input  wire fp32_u   c,
    output logic         out_valid,
    output unpack_stage_t out
);

    logic [9:0] ea_eff;
    logic [9:0] eb_eff;

    function automatic fp_class_t classify(input fp32_u v);
        fp_class_t cls;
        cls.is_nan  = (v.f.exponent == 8'hFF) && (v.f.mantissa != '0);
        cls.is_inf  = (v.f.exponent == 8'hFF) && (v.f.mantissa == '0);
        cls.is_zero = (v.f.exponent == 8'h00) && (v.f.mantissa == '0);
        return cls;
    endfunction

    // Subnormal exponent field reads as 1
    assign ea_eff = (a.f.exponent == 8'h00) ? 10'd1 : {2'b00, a.f.exponent};
    assign eb_eff = (b.f.exponent == 8'h00) ? 10'd1 : {2'b00, b.f.exponent};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out.prod_sign <= a.f.sign ^ b.f.sign;
            out.prod_exp  <= ea_eff + eb_eff - 10'd127;   // Wraps into signed range
            out.mant_a    <= {a.f.exponent != 8'h00, a.f.mantissa};
            out.mant_b    <= {b.f.exponent != 8'h00, b.f.mantissa};
            out.c_sign    <= c.f.sign;
            out.c_exp     <= c.f.exponent;
            out.c_mant    <= {c.f.exponent != 8'h00, c.f.mantissa};
            out.class_a   <= classify(a);
            out.class_b   <= classify(b);
            out.class_c   <= classify(c);
        end
    end

endmodule

`default_nettype wire

//--- source/fma_wb_regs.sv
/*
 * Wishbone classic slave for the FMA unit.
 * ack comes one cycle after cyc and stb. A C write is held off while
 * queued plus in-flight results fill the queue, so the pipeline never
 * stalls. Reading an empty RESULT gives zero. sel is ignored.
 */
`timescale 1ns/1ns
`default_nettype none
`include "fma_defines.svh"

module fma_wb_regs import fp32_pkg::*, wb_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire wb_req_t  bus_req,
    output wb_rsp_t       bus_rsp,
    output logic          issue_valid,
    output fp32_u         issue_a,
    output fp32_u         issue_b,
    output fp32_u         issue_c,
    input  wire logic     result_valid,
    input  wire fp32_u    result
);

    localparam int QW = $clog2(`FMA_QUEUE_DEPTH + 1);
    localparam int PW = $clog2(`FMA_QUEUE_DEPTH);
    localparam int FW = $clog2(`FMA_LATENCY + 1);

    fp32_u         reg_a;
    fp32_u         reg_b;
    fp32_u         reg_c;
    logic [31:0]   queue [`FMA_QUEUE_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [QW-1:0] count;
    logic [FW-1:0] inflight;      // Issued, not yet in the queue
    logic          ack_q;
    logic [31:0]   rdat_q;
    logic          c_write;
    logic          no_room;
    logic          go;
    logic          pop;

    // ------------------------------------------------------------------
    // Access decode
    // ------------------------------------------------------------------
    assign c_write = bus_req.we && (bus_req.adr == `FMA_ADDR_C);
    assign no_room = (count + inflight) >= `FMA_QUEUE_DEPTH;
    assign go      = bus_req.cyc && bus_req.stb && !ack_q && !(c_write && no_room);
    assign pop     = go && !bus_req.we && (bus_req.adr == `FMA_ADDR_RESULT)
                  && (count != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q       <= 1'b0;
            issue_valid <= 1'b0;
            inflight    <= '0;
            count       <= '0;
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            reg_a       <= '0;
            reg_b       <= '0;
            reg_c       <= '0;
        end else begin
            ack_q       <= go;
            issue_valid <= go && c_write;   // Issue shares the ack cycle
            inflight    <= inflight + FW'(go && c_write) - FW'(result_valid);
            count       <= count + QW'(result_valid) - QW'(pop);
            if (result_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (go && bus_req.we) begin
                case (bus_req.adr)
                    `FMA_ADDR_A: reg_a.raw <= bus_req.dat;
                    `FMA_ADDR_B: reg_b.raw <= bus_req.dat;
                    `FMA_ADDR_C: reg_c.raw <= bus_req.dat;
                    default: ;                      // RESULT, STATUS dropped
                endcase
            end
        end
    end

    // Result queue and read data
    always_ff @(posedge clk) begin
        if (result_valid) begin
            queue[wr_ptr] <= result.raw;
        end
        if (go && !bus_req.we) begin
            case (bus_req.adr)
                `FMA_ADDR_A:      rdat_q <= reg_a.raw;
                `FMA_ADDR_B:      rdat_q <= reg_b.raw;
                `FMA_ADDR_C:      rdat_q <= reg_c.raw;
                `FMA_ADDR_RESULT: rdat_q <= (count != '0) ? queue[rd_ptr] : 32'h0;
                `FMA_ADDR_STATUS: rdat_q <= {28'h0, inflight != '0, count};
                default:          rdat_q <= 32'h0;
            endcase
        end
    end

    assign bus_rsp.ack = ack_q;
    assign bus_rsp.dat = rdat_q;

    assign issue_a = reg_a;
    assign issue_b = reg_b;
    assign issue_c = reg_c;

endmodule

`default_nettype wire

//--- source/fp32_pkg.sv
/*
 * Single-precision float types shared by the pipeline stages.
 * Exponents between stages are signed 10-bit and may leave the
 * 0..255 range. Only the final pack clamps them.
 */
`default_nettype none

package fp32_pkg;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } fp32_fields_t;

    // One operand word, raw on the bus or split into IEEE fields
    typedef union packed {
        logic [31:0]  raw;
        fp32_fields_t f;
    } fp32_u;

    typedef struct packed {
        logic is_nan;
        logic is_inf;
        logic is_zero;
    } fp_class_t;

    typedef struct packed {
        logic              prod_sign;
        logic signed [9:0] prod_exp;    // ea + eb - 127
        logic [23:0]       mant_a;
        logic [23:0]       mant_b;
        logic              c_sign;
        logic [7:0]        c_exp;       // Raw field, 0 for subnormal
        logic [23:0]       c_mant;
        fp_class_t         class_a;
        fp_class_t         class_b;
        fp_class_t         class_c;
    } unpack_stage_t;

    typedef struct packed {
        logic [47:0]       prod_mant;   // Binary point below bit 47
        logic signed [9:0] prod_exp;
        logic              prod_sign;
        fp_class_t         prod_class;
        logic              c_sign;
        logic [7:0]        c_exp;
        logic [23:0]       c_mant;
        fp_class_t         class_c;
    } product_stage_t;

    typedef struct packed {
        logic              special;
        logic [31:0]       special_result;
        logic              sign;
        logic signed [9:0] exp;
        logic [95:0]       mag;         // Binary point below bit 94
    } sum_stage_t;

endpackage

`default_nettype wire

//--- source/wb_pkg.sv
/*
 * Wishbone classic request and response bundles.
 * Only full 32-bit word accesses exist, so sel is not carried.
 */
`default_nettype none

package wb_pkg;

    // Master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr;   // Word address
        logic [31:0] dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- verification/fma_tb_vectors.svh
/*
 * FMA test vectors, included inside the testbench module.
 * Expected words assume truncation, one quiet NaN pattern 7FC00001
 * and +0 on exact cancellation.
 */
`ifndef FMA_TB_VECTORS_SVH
`define FMA_TB_VECTORS_SVH

localparam int NUM_VECTORS = 21;

// Four rows from here on share a and b, so only c changes between them
localparam int BURST_FIRST = 17;

// Columns: a, b, c, expected a * b + c
function automatic logic [127:0] vector_row(input int idx);
    case (idx)
        0:  return {32'h40400000, 32'h40800000, 32'h40A00000, 32'h41880000}; // 3*4+5
        1:  return {32'h40000000, 32'h40000000, 32'hC0800000, 32'h00000000}; // 2*2-4
        2:  return {32'hBFC00000, 32'h40000000, 32'h3F800000, 32'hC0000000}; // -1.5*2+1
        3:  return {32'h40000000, 32'hC0400000, 32'h41200000, 32'h40800000}; // 2*-3+10
        4:  return {32'hBF000000, 32'h41000000, 32'hBF800000, 32'hC0A00000}; // -0.5*8-1
        5:  return {32'h3F800001, 32'h3F800001, 32'h00000000, 32'h3F800002};
        6:  return {32'h3F800000, 32'h33800000, 32'h3F800000, 32'h3F800000}; // 1+2^-24
        7:  return {32'h1CC00000, 32'h1C800000, 32'h00000000, 32'h00000300}; // Subnormal
        8:  return {32'h7FC00000, 32'h3F800000, 32'h3F800000, 32'h7FC00001}; // NaN a
        9:  return {32'h3F800000, 32'h3F800000, 32'hFF800123, 32'h7FC00001}; // NaN c
        10: return {32'h7F800000, 32'h00000000, 32'h3F800000, 32'h7FC00001}; // Inf*0
        11: return {32'h7F800000, 32'h3F800000, 32'hFF800000, 32'h7FC00001}; // Inf-inf
        12: return {32'hFF800000, 32'h40000000, 32'h42C80000, 32'hFF800000};
        13: return {32'h40000000, 32'h40400000, 32'hFF800000, 32'hFF800000};
        14: return {32'h80000000, 32'h40400000, 32'hC1234567, 32'hC1234567}; // c as is
        15: return {32'h7F000000, 32'h7F000000, 32'h3F800000, 32'h7F800000}; // Overflow
        16: return {32'hFF000000, 32'h7F000000, 32'h00000000, 32'hFF800000};
        17: return {32'h40400000, 32'h40800000, 32'h3F800000, 32'h41500000}; // 3*4+1
        18: return {32'h40400000, 32'h40800000, 32'hC1400000, 32'h00000000}; // 3*4-12
        19: return {32'h40400000, 32'h40800000, 32'hC1A00000, 32'hC1000000}; // 3*4-20
        20: return {32'h40400000, 32'h40800000, 32'h3E800000, 32'h41440000}; // 3*4+0.25
        default: return '0;
    endcase
endfunction

`endif

//--- verification/fma_tb.sv
/*
 * Testbench for the Wishbone FMA unit.
 * Bus inputs change on the falling clock edge only. The run stops at
 * the first failed check. Queue bound checks peek at the counters
 * inside u_dut.u_regs.
 */
`timescale 1ns/1ns
`default_nettype none
`include "fma_defines.svh"

module fma_tb import wb_pkg::*; ();

    `include "fma_tb_vectors.svh"

    localparam int ACK_TIMEOUT = 20;
    localparam int HOLD_CYCLES = 24;    // Window in which a held C write stays unacked
    localparam int POLL_LIMIT  = 40;

    logic        clk = 1'b0;
    logic        rst_n;
    wb_req_t     bus_req;
    wb_rsp_t     bus_rsp;
    logic [31:0] lfsr_state;
    int          order [NUM_VECTORS];

    always #2 clk = ~clk;

    fma_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic stop_run();
        $display("Checks failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t ns: %s expected %h got %h", $time, name, exp, got);
            stop_run();
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output int unsigned val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = (val << 1) | lfsr_state[0];
        end
    endtask

    // One access, started on a falling edge; drops the request on ack or timeout
    task automatic bus_access(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                              input int timeout, output logic acked,
                              output logic [31:0] rdat);
        int waited;
        waited      = 0;
        acked       = 1'b0;
        rdat        = 32'h0;
        bus_req.cyc = 1'b1;
        bus_req.stb = 1'b1;
        bus_req.we  = we;
        bus_req.adr = adr;
        bus_req.dat = wdat;
        while (!acked && waited < timeout) begin
            @(negedge clk);
            if (bus_rsp.ack) begin
                acked = 1'b1;
                rdat  = bus_rsp.dat;
            end else begin
                waited++;
            end
        end
        bus_req = '0;
    endtask

    task automatic bus_write(input logic [2:0] adr, input logic [31:0] dat);
        logic        acked;
        logic [31:0] unused;
        bus_access(1'b1, adr, dat, ACK_TIMEOUT, acked, unused);
        assert (acked) else begin
            $display("No ack for a write to address %0d at %0t ns", adr, $time);
            stop_run();
        end
    endtask

    task automatic bus_read(input logic [2:0] adr, output logic [31:0] dat);
        logic acked;
        bus_access(1'b0, adr, 32'h0, ACK_TIMEOUT, acked, dat);
        assert (acked) else begin
            $display("No ack for a read of address %0d at %0t ns", adr, $time);
            stop_run();
        end
    endtask

    task automatic issue_vector(input int idx);
        logic [127:0] row;
        row = vector_row(idx);
        bus_write(`FMA_ADDR_A, row[127:96]);
        bus_write(`FMA_ADDR_B, row[95:64]);
        bus_write(`FMA_ADDR_C, row[63:32]);
    endtask

    task automatic read_result(input int idx);
        logic [127:0] row;
        logic [31:0]  rd;
        row = vector_row(idx);
        bus_read(`FMA_ADDR_RESULT, rd);
        check_word($sformatf("bus_rsp.dat (RESULT, vector %0d)", idx), rd, row[31:0]);
    endtask

    // Polls STATUS until n results are queued and nothing is in flight
    task automatic wait_queue(input int n);
        logic [31:0] st;
        int          polls;
        polls = 0;
        st    = 32'hFFFF_FFFF;
        while (st != 32'(n) && polls < POLL_LIMIT) begin
            bus_read(`FMA_ADDR_STATUS, st);
            polls++;
        end
        assert (st == 32'(n)) else begin
            $display("Queue never settled at %0d results, last STATUS %h", n, st);
            stop_run();
        end
    endtask

    // ------------------------------------------------------------------
    // Protocol and queue bound checks
    // ------------------------------------------------------------------
    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        bus_rsp.ack |=> !bus_rsp.ack)
    else begin
        $display("ack held for more than one cycle at %0t ns", $time);
        stop_run();
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        bus_rsp.ack |-> $past(bus_req.cyc && bus_req.stb))
    else begin
        $display("ack without a bus request at %0t ns", $time);
        stop_run();
    end

    queue_bound: assert property (@(posedge clk) disable iff (!rst_n)
        (u_dut.u_regs.count + u_dut.u_regs.inflight) <= `FMA_QUEUE_DEPTH)
    else begin
        $display("Queued plus in-flight results exceed the queue depth at %0t ns", $time);
        stop_run();
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial begin
        logic [127:0] row;
        logic [31:0]  rd;
        logic         acked;
        int unsigned  r;
        int           j;
        int           tmp;
        lfsr_state = 32'hb4da_467b;
        rst_n      = 1'b0;
        bus_req    = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Idle state after reset
        bus_read(`FMA_ADDR_STATUS, rd);
        check_word("bus_rsp.dat (STATUS after reset)", rd, 32'h0);
        bus_read(`FMA_ADDR_RESULT, rd);
        check_word("bus_rsp.dat (empty RESULT)", rd, 32'h0);

        // Register readback, ignored writes
        row = vector_row(0);
        issue_vector(0);
        bus_read(`FMA_ADDR_A, rd);
        check_word("bus_rsp.dat (A)", rd, row[127:96]);
        bus_read(`FMA_ADDR_B, rd);
        check_word("bus_rsp.dat (B)", rd, row[95:64]);
        bus_read(`FMA_ADDR_C, rd);
        check_word("bus_rsp.dat (C)", rd, row[63:32]);
        wait_queue(1);
        bus_write(`FMA_ADDR_STATUS, 32'hFFFF_FFFF);
        bus_write(`FMA_ADDR_RESULT, 32'h1234_5678);
        bus_read(`FMA_ADDR_STATUS, rd);
        check_word("bus_rsp.dat (STATUS after ignored writes)", rd, 32'h1);
        read_result(0);

        // Fisher-Yates shuffle of the vector order
        for (int i = 0; i < NUM_VECTORS; i++) begin
            order[i] = i;
        end
        for (int i = NUM_VECTORS - 1; i > 0; i--) begin
            random_bits(5, r);
            j        = r % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end

        // Four C writes back to back on shared a and b overlap in the pipeline
        row = vector_row(BURST_FIRST);
        bus_write(`FMA_ADDR_A, row[127:96]);
        bus_write(`FMA_ADDR_B, row[95:64]);
        for (int i = 0; i < 4; i++) begin
            row = vector_row(BURST_FIRST + i);
            bus_write(`FMA_ADDR_C, row[63:32]);
        end
        wait_queue(4);

        // Held fifth C write
        row = vector_row(order[0]);
        bus_write(`FMA_ADDR_A, row[127:96]);
        bus_write(`FMA_ADDR_B, row[95:64]);
        bus_access(1'b1, `FMA_ADDR_C, row[63:32], HOLD_CYCLES, acked, rd);
        assert (!acked) else begin
            $display("C write acked at %0t ns although the queue was full", $time);
            stop_run();
        end
        read_result(BURST_FIRST);
        bus_write(`FMA_ADDR_C, row[63:32]);     // Room again
        wait_queue(4);
        for (int i = 1; i < 4; i++) begin
            read_result(BURST_FIRST + i);
        end
        read_result(order[0]);

        // Every vector alone, random gaps
        for (int i = 0; i < NUM_VECTORS; i++) begin
            random_bits(2, r);
            repeat (r) @(negedge clk);
            issue_vector(order[i]);
            bus_read(`FMA_ADDR_STATUS, rd);
            check_word("bus_rsp.dat (STATUS with one in flight)", rd, 32'h8);
            wait_queue(1);
            read_result(order[i]);
        end

        bus_read(`FMA_ADDR_STATUS, rd);
        check_word("bus_rsp.dat (final STATUS)", rd, 32'h0);
        bus_read(`FMA_ADDR_RESULT, rd);
        check_word("bus_rsp.dat (final empty RESULT)", rd, 32'h0);

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+source
+incdir+verification
source/fp32_pkg.sv
source/wb_pkg.sv
source/fma_unpack.sv
source/fma_product.sv
source/fma_align_add.sv
source/fma_normalize.sv
source/fma_wb_regs.sv
source/fma_top.sv
verification/fma_tb.sv
